// ==== rtl/lsu_params.svh ====
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// DTCM geometry
// Doubleword index bits per bank
// Each bank holds 2**LSU_AW doublewords, so the DTCM spans
// 2**(LSU_AW+1) doublewords in total
`define LSU_AW 10

// Destination tag
// Extra rename bits on top of the 5-bit register number
`define LSU_RB 2

// Full tag width as carried in the parameter word
`define LSU_TAG_W (5 + `LSU_RB)

`endif

// ==== rtl/lsu_op_pkg.sv ====
`default_nettype none

`include "lsu_params.svh"

package lsu_op_pkg;

	// Field widths of the parameter word
	localparam int unsigned opc_n = 13;
	localparam int unsigned tag_w = `LSU_TAG_W;
	localparam int unsigned lsu_exeparam_w = opc_n + tag_w + 64 + 64;

	// Field positions, opcode bits at the top
	localparam int unsigned op2_lsb = 0;
	localparam int unsigned op1_lsb = 64;
	localparam int unsigned tag_lsb = 128;

	// One-hot opcode bit positions, lb is the topmost bit
	localparam int unsigned opc_lb = lsu_exeparam_w - 1;
	localparam int unsigned opc_lh = lsu_exeparam_w - 2;
	localparam int unsigned opc_lw = lsu_exeparam_w - 3;
	localparam int unsigned opc_ld = lsu_exeparam_w - 4;
	localparam int unsigned opc_lbu = lsu_exeparam_w - 5;
	localparam int unsigned opc_lhu = lsu_exeparam_w - 6;
	localparam int unsigned opc_lwu = lsu_exeparam_w - 7;
	localparam int unsigned opc_sb = lsu_exeparam_w - 8;
	localparam int unsigned opc_sh = lsu_exeparam_w - 9;
	localparam int unsigned opc_sw = lsu_exeparam_w - 10;
	localparam int unsigned opc_sd = lsu_exeparam_w - 11;
	localparam int unsigned opc_fence_i = lsu_exeparam_w - 12;
	localparam int unsigned opc_fence = lsu_exeparam_w - 13;

	// Destination register tag with rename bits
	typedef logic [tag_w-1:0] lsu_tag_t;

	// Access size, 1/2/4/8 bytes
	typedef enum logic [1:0] {
		size_b = 2'd0,
		size_h = 2'd1,
		size_w = 2'd2,
		size_d = 2'd3
	} lsu_size_t;

endpackage

`default_nettype wire

// ==== rtl/lsu_mem_pkg.sv ====
`default_nettype none

`include "lsu_params.svh"

package lsu_mem_pkg;

	// Bank geometry
	localparam int unsigned lane_bytes = 8;
	localparam int unsigned bank_aw = `LSU_AW;
	localparam int unsigned bank_depth = 1 << bank_aw;

	// One bank lane of data
	typedef logic [8*lane_bytes-1:0] lane_data_t;

	// Byte write enables for one lane
	typedef logic [lane_bytes-1:0] lane_mask_t;

	// Doubleword index inside one bank
	// Byte address bit 3 picks the bank, so this is byte address [bank_aw+3:4]
	typedef logic [bank_aw-1:0] bank_addr_t;

endpackage

`default_nettype wire

// ==== rtl/lsu_decode.sv ====
`default_nettype none

module lsu_decode (
	input wire CLK,
	input wire rst_n,
	input wire lsu_exeparam_valid,
	input wire [lsu_op_pkg::lsu_exeparam_w-1:0] lsu_exeparam,
	input wire flush,
	output logic st_en,
	output lsu_op_pkg::lsu_size_t st_size,
	output logic [63:0] op1,
	output logic [63:0] op2,
	output logic ld_en_q,
	output lsu_op_pkg::lsu_size_t ld_size_q,
	output logic ld_unsigned_q,
	output logic [2:0] ld_offset_q,
	output logic ld_odd_q,
	output logic lsu_writeback_valid,
	output lsu_op_pkg::lsu_tag_t lsu_rd0_qout
);
	import lsu_op_pkg::*;

	logic [opc_n-1:0] opc;
	lsu_tag_t tag;
	logic accept;
	logic is_load;
	logic is_store;
	logic is_fence;
	logic is_unsigned;
	lsu_size_t ld_size;

	// Field unpack
	assign opc = lsu_exeparam[opc_lb -: opc_n];
	assign tag = lsu_exeparam[tag_lsb +: tag_w];
	assign op1 = lsu_exeparam[op1_lsb +: 64];
	assign op2 = lsu_exeparam[op2_lsb +: 64];

	// Ready is tied high, so valid alone accepts
	assign accept = lsu_exeparam_valid & ~flush;

	// Opcode classes
	assign is_load = lsu_exeparam[opc_lb] | lsu_exeparam[opc_lh] | lsu_exeparam[opc_lw]
		| lsu_exeparam[opc_ld] | lsu_exeparam[opc_lbu] | lsu_exeparam[opc_lhu]
		| lsu_exeparam[opc_lwu];
	assign is_store = lsu_exeparam[opc_sb] | lsu_exeparam[opc_sh] | lsu_exeparam[opc_sw]
		| lsu_exeparam[opc_sd];
	// Fences only retire, no memory side effect here
	assign is_fence = lsu_exeparam[opc_fence_i] | lsu_exeparam[opc_fence];
	assign is_unsigned = lsu_exeparam[opc_lbu] | lsu_exeparam[opc_lhu] | lsu_exeparam[opc_lwu];

	// Store side goes straight to the banks this cycle
	assign st_en = accept & is_store;

	always_comb begin
		if (lsu_exeparam[opc_sb])
			st_size = size_b;
		else if (lsu_exeparam[opc_sh])
			st_size = size_h;
		else if (lsu_exeparam[opc_sw])
			st_size = size_w;
		else
			st_size = size_d;
	end

	// Signed and unsigned loads fold into one size
	always_comb begin
		if (lsu_exeparam[opc_lb] | lsu_exeparam[opc_lbu])
			ld_size = size_b;
		else if (lsu_exeparam[opc_lh] | lsu_exeparam[opc_lhu])
			ld_size = size_h;
		else if (lsu_exeparam[opc_lw] | lsu_exeparam[opc_lwu])
			ld_size = size_w;
		else
			ld_size = size_d;
	end

	// Load controls line up with the bank read data one cycle later
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			ld_en_q <= 1'b0;
			ld_size_q <= size_b;
			ld_unsigned_q <= 1'b0;
			ld_offset_q <= 3'd0;
			ld_odd_q <= 1'b0;
			lsu_writeback_valid <= 1'b0;
			lsu_rd0_qout <= '0;
		end else begin
			ld_en_q <= accept & is_load;
			ld_size_q <= ld_size;
			ld_unsigned_q <= is_unsigned;
			// Byte offset and bank parity of the first doubleword
			ld_offset_q <= op1[2:0];
			ld_odd_q <= op1[3];
			// Every known operation retires, fences included
			lsu_writeback_valid <= accept & (is_load | is_store | is_fence);
			if (lsu_exeparam_valid)
				lsu_rd0_qout <= tag;
		end
	end

	// Execute stage issues a single operation per word
	a_opc_onehot: assert property (
		@(posedge CLK) disable iff (!rst_n)
		lsu_exeparam_valid |-> $onehot0(opc)
	) else $error("lsu_decode: more than one opcode bit set");

endmodule

`default_nettype wire

// ==== rtl/lsu_store_lanes.sv ====
`default_nettype none

module lsu_store_lanes (
	input wire st_en,
	input wire lsu_op_pkg::lsu_size_t st_size,
	input wire [63:0] op1,
	input wire [63:0] op2,
	output lsu_mem_pkg::bank_addr_t addr_a,
	output lsu_mem_pkg::bank_addr_t addr_b,
	output lsu_mem_pkg::lane_data_t wdata_a,
	output lsu_mem_pkg::lane_data_t wdata_b,
	output lsu_mem_pkg::lane_mask_t wmask_a,
	output lsu_mem_pkg::lane_mask_t wmask_b,
	output logic wen_a,
	output logic wen_b
);
	import lsu_op_pkg::*;
	import lsu_mem_pkg::*;

	logic [63:0] addr_a_raw;
	logic [2:0] offset;
	logic [7:0] size_bytes;
	logic [15:0] mask;
	logic [127:0] data;

	assign offset = op1[2:0];

	// Bank A is the even doubleword
	// Odd start means the access spills into the next even one
	assign addr_a_raw = op1 + {60'd0, op1[3], 3'b000};
	assign addr_a = addr_a_raw[4 +: bank_aw];
	// Bank B shares the index, op1 bit 3 forced high changes nothing above bit 3
	assign addr_b = op1[4 +: bank_aw];

	// Byte count as a contiguous mask
	always_comb begin
		case (st_size)
			size_b: size_bytes = 8'h01;
			size_h: size_bytes = 8'h03;
			size_w: size_bytes = 8'h0f;
			size_d: size_bytes = 8'hff;
			default: size_bytes = 8'h00;
		endcase
	end

	// 16-byte window starting at the first doubleword
	assign mask = {8'h00, size_bytes} << offset;
	assign data = {64'd0, op2} << {offset, 3'b000};

	// Low half belongs to whichever bank holds the first doubleword
	always_comb begin
		if (op1[3]) begin
			wmask_b = mask[7:0];
			wmask_a = mask[15:8];
			wdata_b = data[63:0];
			wdata_a = data[127:64];
		end else begin
			wmask_a = mask[7:0];
			wmask_b = mask[15:8];
			wdata_a = data[63:0];
			wdata_b = data[127:64];
		end
	end

	// A bank only writes when it owns at least one byte
	assign wen_a = st_en & (|wmask_a);
	assign wen_b = st_en & (|wmask_b);

endmodule

`default_nettype wire

// ==== rtl/dtcm_bank.sv ====
`default_nettype none

module dtcm_bank (
	input wire CLK,
	input wire rst_n,
	input wire lsu_mem_pkg::bank_addr_t addr,
	input wire lsu_mem_pkg::lane_data_t wdata,
	input wire lsu_mem_pkg::lane_mask_t wmask,
	input wire wen,
	output lsu_mem_pkg::lane_data_t rdata
);
	import lsu_mem_pkg::*;

	// Doubleword array
	lane_data_t mem [bank_depth];

	// Byte-masked write at the issue edge
	always_ff @(posedge CLK) begin
		if (wen) begin
			for (int i = 0; i < lane_bytes; i++) begin
				if (wmask[i])
					mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
			end
		end
	end

	// Read every cycle
	// A store never shares a cycle with a load, so old data here is fine
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n)
			rdata <= '0;
		else
			rdata <= mem[addr];
	end

	// Store lanes only enable a bank that owns bytes of the access
	a_wen_mask: assert property (
		@(posedge CLK) disable iff (!rst_n)
		wen |-> (wmask != '0)
	) else $error("dtcm_bank: write enable with empty byte mask");

endmodule

`default_nettype wire

// ==== rtl/lsu_load_align.sv ====
`default_nettype none

module lsu_load_align (
	input wire lsu_mem_pkg::lane_data_t rdata_a,
	input wire lsu_mem_pkg::lane_data_t rdata_b,
	input wire ld_en_q,
	input wire lsu_op_pkg::lsu_size_t ld_size_q,
	input wire ld_unsigned_q,
	input wire [2:0] ld_offset_q,
	input wire ld_odd_q,
	output logic [63:0] lsu_res_qout
);
	import lsu_op_pkg::*;
	import lsu_mem_pkg::*;

	logic [127:0] window;
	logic [127:0] shifted;
	logic [63:0] field;

	// First doubleword in the low half
	assign window = ld_odd_q ? {rdata_a, rdata_b} : {rdata_b, rdata_a};

	// Bring the addressed byte down to bit 0
	assign shifted = window >> {ld_offset_q, 3'b000};
	assign field = shifted[63:0];

	// Size select and extension
	always_comb begin
		if (!ld_en_q) begin
			lsu_res_qout = 64'd0;
		end else begin
			case (ld_size_q)
				size_b: lsu_res_qout = ld_unsigned_q ? {56'd0, field[7:0]}
					: {{56{field[7]}}, field[7:0]};
				size_h: lsu_res_qout = ld_unsigned_q ? {48'd0, field[15:0]}
					: {{48{field[15]}}, field[15:0]};
				size_w: lsu_res_qout = ld_unsigned_q ? {32'd0, field[31:0]}
					: {{32{field[31]}}, field[31:0]};
				size_d: lsu_res_qout = field;
				default: lsu_res_qout = 64'd0;
			endcase
		end
	end

	// Registered size from decode must be known while a load is live
	always_comb begin
		if (ld_en_q)
			a_ld_size: assert (!$isunknown(ld_size_q))
			else $error("lsu_load_align: active load with unknown size");
	end

endmodule

`default_nettype wire

// ==== rtl/lsu.sv ====
`default_nettype none

module lsu (
	input wire CLK,
	input wire rst_n,
	input wire lsu_exeparam_valid,
	input wire [lsu_op_pkg::lsu_exeparam_w-1:0] lsu_exeparam,
	input wire flush,
	output logic lsu_exeparam_ready,
	output logic lsu_writeback_valid,
	output logic [63:0] lsu_res_qout,
	output lsu_op_pkg::lsu_tag_t lsu_rd0_qout
);
	import lsu_op_pkg::*;
	import lsu_mem_pkg::*;

	// Decode to store lanes
	logic st_en;
	lsu_size_t st_size;
	logic [63:0] op1;
	logic [63:0] op2;

	// Decode to load align
	logic ld_en_q;
	lsu_size_t ld_size_q;
	logic ld_unsigned_q;
	logic [2:0] ld_offset_q;
	logic ld_odd_q;

	// Bank ports
	bank_addr_t addr_a;
	bank_addr_t addr_b;
	lane_data_t wdata_a;
	lane_data_t wdata_b;
	lane_mask_t wmask_a;
	lane_mask_t wmask_b;
	logic wen_a;
	logic wen_b;
	lane_data_t rdata_a;
	lane_data_t rdata_b;

	// DTCM only, never stalls
	assign lsu_exeparam_ready = 1'b1;

	lsu_decode i_decode (
		.CLK(CLK),
		.rst_n(rst_n),
		.lsu_exeparam_valid(lsu_exeparam_valid),
		.lsu_exeparam(lsu_exeparam),
		.flush(flush),
		.st_en(st_en),
		.st_size(st_size),
		.op1(op1),
		.op2(op2),
		.ld_en_q(ld_en_q),
		.ld_size_q(ld_size_q),
		.ld_unsigned_q(ld_unsigned_q),
		.ld_offset_q(ld_offset_q),
		.ld_odd_q(ld_odd_q),
		.lsu_writeback_valid(lsu_writeback_valid),
		.lsu_rd0_qout(lsu_rd0_qout)
	);

	lsu_store_lanes i_store_lanes (
		.st_en(st_en),
		.st_size(st_size),
		.op1(op1),
		.op2(op2),
		.addr_a(addr_a),
		.addr_b(addr_b),
		.wdata_a(wdata_a),
		.wdata_b(wdata_b),
		.wmask_a(wmask_a),
		.wmask_b(wmask_b),
		.wen_a(wen_a),
		.wen_b(wen_b)
	);

	// Even doublewords
	dtcm_bank i_dtcm_a (
		.CLK(CLK),
		.rst_n(rst_n),
		.addr(addr_a),
		.wdata(wdata_a),
		.wmask(wmask_a),
		.wen(wen_a),
		.rdata(rdata_a)
	);

	// Odd doublewords
	dtcm_bank i_dtcm_b (
		.CLK(CLK),
		.rst_n(rst_n),
		.addr(addr_b),
		.wdata(wdata_b),
		.wmask(wmask_b),
		.wen(wen_b),
		.rdata(rdata_b)
	);

	lsu_load_align i_load_align (
		.rdata_a(rdata_a),
		.rdata_b(rdata_b),
		.ld_en_q(ld_en_q),
		.ld_size_q(ld_size_q),
		.ld_unsigned_q(ld_unsigned_q),
		.ld_offset_q(ld_offset_q),
		.ld_odd_q(ld_odd_q),
		.lsu_res_qout(lsu_res_qout)
	);

endmodule

`default_nettype wire

// ==== verif/lsu_tb.sv ====
`default_nettype none

`include "lsu_params.svh"

module lsu_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import lsu_op_pkg::*;

	localparam int clk_period = 40;
	localparam int drive_dly = 2;
	localparam int n_random = 200;
	// Both banks together, in bytes
	localparam int mem_bytes = 1 << (`LSU_AW + 4);

	logic CLK;
	logic rst_n;
	logic lsu_exeparam_valid;
	logic [lsu_exeparam_w-1:0] lsu_exeparam;
	logic flush;
	wire lsu_exeparam_ready;
	wire lsu_writeback_valid;
	wire [63:0] lsu_res_qout;
	wire [tag_w-1:0] lsu_rd0_qout;

	// Directed tests, one entry per line of the tests file
	string q_mnem[$];
	logic [63:0] q_op1[$];
	logic [63:0] q_op2[$];
	lsu_tag_t q_tag[$];
	logic q_flush[$];
	logic q_valid[$];
	logic [63:0] q_res[$];
	logic loaded = 1'b0;

	// Operation in flight, checked one cycle after issue
	logic pend_live = 1'b0;
	string pend_name;
	logic pend_valid;
	logic [63:0] pend_res;
	lsu_tag_t pend_tag;

	int n_tests = 0;
	int n_bad = 0;
	int n_errors = 0;

	logic [31:0] lcg_state = 32'd99065;
	// Little-endian byte image of the DTCM
	logic [7:0] mem_model [mem_bytes];

	string st_names[4] = '{"sb", "sh", "sw", "sd"};
	string ld_s_names[4] = '{"lb", "lh", "lw", "ld"};
	string ld_u_names[4] = '{"lbu", "lhu", "lwu", "ld"};

	lsu UUT (
		.CLK(CLK),
		.rst_n(rst_n),
		.lsu_exeparam_valid(lsu_exeparam_valid),
		.lsu_exeparam(lsu_exeparam),
		.flush(flush),
		.lsu_exeparam_ready(lsu_exeparam_ready),
		.lsu_writeback_valid(lsu_writeback_valid),
		.lsu_res_qout(lsu_res_qout),
		.lsu_rd0_qout(lsu_rd0_qout)
	);

	initial begin : clock_gen
		CLK = 1'b0;
		forever #(clk_period / 2) CLK = ~CLK;
	end

	// Upper bits of the LCG, the low ones repeat too soon
	function automatic logic [15:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[30:15];
	endfunction

	// One-hot bit index, -1 for no operation
	function automatic int opc_pos(input string mnem);
		case (mnem)
			"lb": return opc_lb;
			"lh": return opc_lh;
			"lw": return opc_lw;
			"ld": return opc_ld;
			"lbu": return opc_lbu;
			"lhu": return opc_lhu;
			"lwu": return opc_lwu;
			"sb": return opc_sb;
			"sh": return opc_sh;
			"sw": return opc_sw;
			"sd": return opc_sd;
			"fence_i": return opc_fence_i;
			"fence": return opc_fence;
			default: return -1;
		endcase
	endfunction

	// Byte n of the data goes to address + n, wrapping at the top
	function automatic void mem_write(input logic [63:0] addr, input int sz,
		input logic [63:0] data);
		for (int i = 0; i < (1 << sz); i++)
			mem_model[int'((addr + 64'(i)) % 64'(mem_bytes))] = data[i*8 +: 8];
	endfunction

	function automatic logic [63:0] mem_read(input logic [63:0] addr, input int sz,
		input logic uns);
		logic [63:0] v;
		int n;
		v = '0;
		n = 1 << sz;
		for (int i = 0; i < n; i++)
			v[i*8 +: 8] = mem_model[int'((addr + 64'(i)) % 64'(mem_bytes))];
		// Sign fill from the top bit of the field
		if (!uns && v[n*8-1]) begin
			for (int i = n; i < 8; i++)
				v[i*8 +: 8] = 8'hff;
		end
		return v;
	endfunction

	task automatic check_value(input string sig, input logic [63:0] exp,
		input logic [63:0] act);
		assert (act === exp) else begin
			$display("[ERROR] %0t %s expected %h actual %h", $time, sig, exp, act);
			n_errors++;
		end
	endtask

	task automatic finish_test(input string name, input int errs_before);
		n_tests++;
		if (n_errors == errs_before) begin
			$display("ok   %s", name);
		end else begin
			n_bad++;
			$display("FAIL %s", name);
		end
	endtask

	task automatic check_result();
		int errs;
		if (!pend_live)
			return;
		errs = n_errors;
		check_value("lsu_exeparam_ready", 64'd1, 64'(lsu_exeparam_ready));
		check_value("lsu_writeback_valid", 64'(pend_valid), 64'(lsu_writeback_valid));
		check_value("lsu_res_qout", pend_res, lsu_res_qout);
		// Tag only means something with valid
		if (pend_valid)
			check_value("lsu_rd0_qout", 64'(pend_tag), 64'(lsu_rd0_qout));
		finish_test(pend_name, errs);
	endtask

	// Called at edge + drive_dly, returns at the next edge + drive_dly
	task automatic issue_op(input string name, input int pos, input logic [63:0] a,
		input logic [63:0] d, input lsu_tag_t t, input logic f, input logic ev,
		input logic [63:0] er);
		lsu_exeparam = '0;
		if (pos >= 0)
			lsu_exeparam[pos] = 1'b1;
		lsu_exeparam[tag_lsb +: tag_w] = t;
		lsu_exeparam[op1_lsb +: 64] = a;
		lsu_exeparam[op2_lsb +: 64] = d;
		lsu_exeparam_valid = (pos >= 0);
		flush = f;
		// Outputs still show the previous operation here
		#(clk_period - drive_dly - 1);
		check_result();
		pend_live = 1'b1;
		pend_name = name;
		pend_valid = ev;
		pend_res = er;
		pend_tag = t;
		@(posedge CLK);
		#(drive_dly);
	endtask

	task automatic load_tests();
		int fd;
		string line;
		string mnem;
		logic [63:0] a;
		logic [63:0] d;
		logic [63:0] er;
		int t;
		int f;
		int ev;
		fd = $fopen("verif/lsu_tests.txt", "r");
		if (fd == 0) begin
			$display("Cannot open verif/lsu_tests.txt, no directed tests were run");
			n_errors++;
			return;
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			if ($sscanf(line, "%s %h %h %h %d %d %h", mnem, a, d, t, f, ev, er) != 7) begin
				$display("Malformed line in the tests file: %s", line);
				n_errors++;
			end else begin
				q_mnem.push_back(mnem);
				q_op1.push_back(a);
				q_op2.push_back(d);
				q_tag.push_back(lsu_tag_t'(t));
				q_flush.push_back(f != 0);
				q_valid.push_back(ev != 0);
				q_res.push_back(er);
			end
		end
		$fclose(fd);
	endtask

	task automatic check_reset_state();
		int errs;
		errs = n_errors;
		check_value("lsu_writeback_valid", 64'd0, 64'(lsu_writeback_valid));
		check_value("lsu_res_qout", 64'd0, lsu_res_qout);
		check_value("lsu_rd0_qout", 64'd0, 64'(lsu_rd0_qout));
		finish_test("reset state", errs);
	endtask

	task automatic run_directed();
		int pos;
		for (int i = 0; i < q_mnem.size(); i++) begin
			pos = opc_pos(q_mnem[i]);
			if (pos < 0 && q_mnem[i] != "idle") begin
				$display("Unknown opcode %s in the tests file", q_mnem[i]);
				n_errors++;
			end
			issue_op($sformatf("directed %0d %s", i + 1, q_mnem[i]), pos, q_op1[i], q_op2[i],
				q_tag[i], q_flush[i], q_valid[i], q_res[i]);
		end
	endtask

	// Store then load back at the same address, load no wider than the store
	task automatic run_random();
		logic [31:0] raw;
		logic [63:0] addr;
		logic [63:0] data;
		logic [15:0] r16;
		logic uns;
		int st_sz;
		int ld_sz;
		string ld_nm;
		for (int i = 0; i < n_random; i++) begin
			raw = {lcg_next(), lcg_next()};
			addr = 64'(raw % 32'(mem_bytes));
			data = {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
			st_sz = int'(lcg_next() % 16'd4);
			r16 = lcg_next();
			uns = r16[15];
			ld_sz = int'(r16[7:0]) % (st_sz + 1);
			ld_nm = uns ? ld_u_names[ld_sz] : ld_s_names[ld_sz];
			mem_write(addr, st_sz, data);
			issue_op($sformatf("random %0d %s", i, st_names[st_sz]), opc_pos(st_names[st_sz]),
				addr, data, lsu_tag_t'(lcg_next()), 1'b0, 1'b1, 64'd0);
			issue_op($sformatf("random %0d %s", i, ld_nm), opc_pos(ld_nm), addr, 64'd0,
				lsu_tag_t'(lcg_next()), 1'b0, 1'b1, mem_read(addr, ld_sz, uns));
		end
	endtask

	initial begin : main
		rst_n = 1'b0;
		lsu_exeparam_valid = 1'b0;
		lsu_exeparam = '0;
		flush = 1'b0;
		$timeformat(-9, 0, " ns", 0);
		load_tests();
		loaded = 1'b1;
		repeat (16) @(posedge CLK);
		#(drive_dly);
		rst_n = 1'b1;
		check_reset_state();
		run_directed();
		run_random();
		// One idle cycle so the last load gets checked
		issue_op("drain", -1, 64'd0, 64'd0, '0, 1'b0, 1'b0, 64'd0);
		$display("%0d tests run, %0d failed, %0d check errors", n_tests, n_bad, n_errors);
		if (n_errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	// Budget is one cycle per operation plus slack for reset
	initial begin : watchdog
		longint limit;
		wait (loaded);
		limit = (longint'(q_mnem.size()) + 2 * n_random + 32) * clk_period;
		#(limit);
		$display("Run timed out before all tests finished");
		$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/lsu_tests.txt ====
# op  op1(hex)  op2(hex)  tag(hex)  flush  exp_valid  exp_result(hex)
# idle issues nothing that cycle, all values little-endian
sd 100 1122334455667788 01 0 1 0
ld 100 0 02 0 1 1122334455667788
sb 103 aa 03 0 1 0
ld 100 0 04 0 1 11223344aa667788
lb 103 0 05 0 1 ffffffffffffffaa
lbu 103 0 06 0 1 00000000000000aa
lb 101 0 07 0 1 0000000000000077
sh 104 beef 08 0 1 0
lh 104 0 09 0 1 ffffffffffffbeef
lhu 104 0 0a 0 1 000000000000beef
sw 108 80001234 0b 0 1 0
lw 108 0 0c 0 1 ffffffff80001234
lwu 108 0 0d 0 1 0000000080001234
ld 100 0 0e 0 1 1122beefaa667788
# Odd doubleword into the next even one
sd 10c cafef00d12345678 10 0 1 0
ld 10c 0 11 0 1 cafef00d12345678
ld 108 0 12 0 1 1234567880001234
# Even doubleword into the next odd one
sw 106 deadbeef 13 0 1 0
lwu 106 0 14 0 1 00000000deadbeef
lh 107 0 15 0 1 ffffffffffffadbe
ld 104 0 16 0 1 8000deadbeefbeef
# Top of the DTCM wraps to address 0
sd 3ffc 8877665544332211 17 0 1 0
ld 3ffc 0 18 0 1 8877665544332211
lwu 0 0 19 0 1 0000000088776655
# Flushed operations
sd 200 0123456789abcdef 20 0 1 0
sd 200 ffffffffffffffff 21 1 0 0
ld 200 0 22 0 1 0123456789abcdef
ld 200 0 23 1 0 0
fence 0 0 1f 0 1 0
fence_i 0 0 7f 0 1 0
idle 0 0 00 0 0 0

// ==== list.f ====
+incdir+rtl
rtl/lsu_op_pkg.sv
rtl/lsu_mem_pkg.sv
rtl/lsu_decode.sv
rtl/lsu_store_lanes.sv
rtl/dtcm_bank.sv
rtl/lsu_load_align.sv
rtl/lsu.sv
verif/lsu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the LSU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps --top-module lsu_tb \
	-f list.f -o lsu_sim

# Run from the project root so the tests file path resolves
sim_out=$(./obj_dir/lsu_sim)
echo "$sim_out"

if echo "$sim_out" | grep -qx "test passed"; then
	exit 0
else
	exit 1
fi
